// File: hw/dtim_pkg.sv
`default_nettype none

package dtim_pkg;

  typedef logic [31:0] addr_t;
  typedef logic [31:0] data_t;

  // zero strobe marks a read.
  typedef logic [3:0] strb_t;

  // ------------------------------
  // core and memory ports
  // ------------------------------

  typedef struct packed {
    logic  valid;
    logic  fence;
    addr_t addr;
    data_t wdata;
    strb_t wstrb;
  } core_req_t;

  typedef struct packed {
    logic  ready;
    data_t rdata;
  } core_rsp_t;

  typedef struct packed {
    logic  valid;
    addr_t addr;
    data_t wdata;
    strb_t wstrb;
  } mem_req_t;

  typedef struct packed {
    logic  ready;
    data_t rdata;
  } mem_rsp_t;

  typedef enum logic [2:0] {
    acc_none,
    acc_hit,
    acc_miss,
    acc_uncached,
    acc_fence
  } access_e;

  typedef enum logic [1:0] {
    st_idle,
    st_miss,
    st_uncached,
    st_fence
  } ctrl_state_e;

  localparam logic [31:0] default_index_bits = 32'd4;
  localparam logic [31:0] default_base_addr = 32'h0000_1000;
  localparam logic [31:0] default_top_addr = 32'h0000_2000;

endpackage

`default_nettype wire

// File: hw/dtim_ram.sv
`default_nettype none

module dtim_ram #(
  parameter int index_bits = 4
) (
  input  wire logic                        clock,
  input  wire logic [index_bits-1:0]       rd_index,
  output logic [30-index_bits+34-1:0]      rd_entry,
  input  wire logic                        wr_en,
  input  wire logic [index_bits-1:0]       wr_index,
  input  wire logic [30-index_bits+34-1:0] wr_entry
);

  localparam int tag_bits = 30 - index_bits;
  localparam int entry_bits = tag_bits + 34;
  localparam int depth = 1 << index_bits;

  // every line starts unlocked.
  logic [entry_bits-1:0] lines [depth] = '{default: '0};

  // read before write, so a same cycle update shows on the following read.
  always_ff @(posedge clock) begin
    if (wr_en) begin
      lines[wr_index] <= wr_entry;
    end
    rd_entry <= lines[rd_index];
  end

endmodule

`default_nettype wire

// File: hw/dtim_lookup.sv
`default_nettype none

module dtim_lookup import dtim_pkg::*; #(
  parameter int    index_bits = 4,
  parameter addr_t base_addr = 32'h0000_1000,
  parameter addr_t top_addr = 32'h0000_2000
) (
  input  wire logic                        clock,
  input  wire logic                        reset,
  input  wire core_req_t                   req,
  output logic [index_bits-1:0]            rd_index,
  input  wire logic [30-index_bits+34-1:0] rd_entry,
  output access_e                          kind,
  output core_req_t                        held_req,
  output data_t                            line_data,
  output logic                             line_dirty
);

  localparam int tag_bits = 30 - index_bits;
  localparam int entry_bits = tag_bits + 34;

  logic                entry_lock;
  logic [tag_bits-1:0] entry_tag;
  logic [tag_bits-1:0] req_tag;
  logic                in_window;

  // array read starts together with the request register.
  assign rd_index = req.addr[index_bits+1:2];

  always_ff @(posedge clock) begin
    if (req.valid) begin
      held_req <= req;
    end
    if (!reset) begin
      held_req.valid <= 1'b0;
    end else begin
      held_req.valid <= req.valid;
    end
  end

  assign entry_lock = rd_entry[entry_bits-1];
  assign line_dirty = rd_entry[entry_bits-2];
  assign entry_tag = rd_entry[entry_bits-3:32];
  assign line_data = rd_entry[31:0];

  assign req_tag = held_req.addr[31:index_bits+2];
  assign in_window = (held_req.addr >= base_addr) && (held_req.addr < top_addr);

  always_comb begin
    if (!held_req.valid) begin
      kind = acc_none;
    end else if (held_req.fence) begin
      kind = acc_fence;
    end else if (!in_window) begin
      kind = acc_uncached;
    end else if (!entry_lock) begin
      kind = acc_miss;
    end else if (entry_tag != req_tag) begin
      // locked by another address, never evicted.
      kind = acc_uncached;
    end else begin
      kind = acc_hit;
    end
  end

endmodule

`default_nettype wire

// File: hw/dtim_flush.sv
`default_nettype none

module dtim_flush import dtim_pkg::*; #(
  parameter int index_bits = 4
) (
  input  wire logic                        clock,
  input  wire logic                        reset,
  input  wire logic                        start,
  input  wire logic                        step,
  output logic [index_bits-1:0]            rd_index,
  input  wire logic [30-index_bits+34-1:0] rd_entry,
  output mem_req_t                         wb_req,
  output logic                             clear_en,
  output logic [index_bits-1:0]            clear_index,
  output logic                             done,
  output logic                             active
);

  localparam int tag_bits = 30 - index_bits;
  localparam int entry_bits = tag_bits + 34;

  logic [index_bits-1:0] index;
  logic                  have;
  logic                  advance;
  logic                  entry_lock;
  logic                  entry_dirty;
  logic [tag_bits-1:0]   entry_tag;

  assign entry_lock = rd_entry[entry_bits-1];
  assign entry_dirty = rd_entry[entry_bits-2];
  assign entry_tag = rd_entry[entry_bits-3:32];

  // have is set once the entry at index sits on rd_entry.
  assign advance = active && have && step;

  // look ahead so the next entry is ready when the step is taken.
  assign rd_index = advance ? index + 1'b1 : index;

  always_comb begin
    wb_req = '0;
    wb_req.valid = advance && entry_lock && entry_dirty;
    wb_req.addr = {entry_tag, index, 2'b00};
    wb_req.wdata = rd_entry[31:0];
    wb_req.wstrb = 4'hf;
  end

  assign clear_en = advance;
  assign clear_index = index;
  assign done = advance && (index == '1);

  always_ff @(posedge clock) begin
    if (!reset) begin
      active <= 1'b0;
      have <= 1'b0;
      index <= '0;
    end else if (start) begin
      active <= 1'b1;
      have <= 1'b0;
      index <= '0;
    end else if (active) begin
      have <= 1'b1;
      if (advance) begin
        if (index == '1) begin
          active <= 1'b0;
        end else begin
          index <= index + 1'b1;
        end
      end
    end
  end

endmodule

`default_nettype wire

// File: hw/dtim_ctrl.sv
`default_nettype none

module dtim_ctrl import dtim_pkg::*; #(
  parameter int index_bits = 4
) (
  input  wire logic                   clock,
  input  wire logic                   reset,
  input  wire access_e                kind,
  input  wire core_req_t              held_req,
  input  wire data_t                  line_data,
  input  wire logic                   line_dirty,
  input  wire mem_rsp_t               mem_rsp,
  input  wire mem_req_t               flush_wb,
  input  wire logic                   flush_done,
  input  wire logic                   clear_en,
  input  wire logic [index_bits-1:0]  clear_index,
  output core_rsp_t                   rsp,
  output mem_req_t                    mem_req,
  output logic                        flush_start,
  output logic                        flush_step,
  output logic                        wr_en,
  output logic [index_bits-1:0]       wr_index,
  output logic [30-index_bits+34-1:0] wr_entry
);

  localparam int tag_bits = 30 - index_bits;

  ctrl_state_e state;
  ctrl_state_e state_n;
  logic        wb_wait;
  logic        wb_wait_n;
  logic        draining;
  logic        draining_n;

  logic [tag_bits-1:0]   req_tag;
  logic [index_bits-1:0] req_index;
  addr_t                 word_addr;
  logic                  is_store;

  function automatic data_t merge_bytes(data_t base, data_t bytes, strb_t strb);
    data_t result;
    result = base;
    for (int i = 0; i < 4; i++) begin
      if (strb[i]) begin
        result[8*i +: 8] = bytes[8*i +: 8];
      end
    end
    return result;
  endfunction

  // held request stays put until its response.
  assign req_tag = held_req.addr[31:index_bits+2];
  assign req_index = held_req.addr[index_bits+1:2];
  assign word_addr = {held_req.addr[31:2], 2'b00};
  assign is_store = |held_req.wstrb;

  always_comb begin
    state_n = state;
    wb_wait_n = wb_wait;
    draining_n = draining;
    rsp = '0;
    mem_req = '0;
    flush_start = 1'b0;
    flush_step = 1'b0;
    wr_en = 1'b0;
    wr_index = req_index;
    wr_entry = '0;

    case (state)
      st_idle: begin
        case (kind)
          acc_hit: begin
            rsp.ready = 1'b1;
            rsp.rdata = line_data;
            if (is_store) begin
              wr_en = 1'b1;
              wr_entry = {1'b1, line_dirty | is_store, req_tag,
                          merge_bytes(line_data, held_req.wdata, held_req.wstrb)};
            end
          end
          acc_miss: begin
            mem_req.valid = 1'b1;
            mem_req.addr = word_addr;
            state_n = st_miss;
          end
          acc_uncached: begin
            mem_req.valid = 1'b1;
            mem_req.addr = word_addr;
            mem_req.wdata = held_req.wdata;
            mem_req.wstrb = held_req.wstrb;
            state_n = st_uncached;
          end
          acc_fence: begin
            flush_start = 1'b1;
            state_n = st_fence;
          end
          default: begin
          end
        endcase
      end

      st_miss: begin
        if (mem_rsp.ready) begin
          // core sees the memory word, the line gets the merged one.
          rsp.ready = 1'b1;
          rsp.rdata = mem_rsp.rdata;
          wr_en = 1'b1;
          wr_entry = {1'b1, is_store, req_tag,
                      merge_bytes(mem_rsp.rdata, held_req.wdata, held_req.wstrb)};
          state_n = st_idle;
        end
      end

      st_uncached: begin
        if (mem_rsp.ready) begin
          rsp.ready = 1'b1;
          rsp.rdata = mem_rsp.rdata;
          state_n = st_idle;
        end
      end

      st_fence: begin
        if (wb_wait && mem_rsp.ready) begin
          wb_wait_n = 1'b0;
        end
        if (draining) begin
          // last write-back still in flight.
          if (mem_rsp.ready) begin
            rsp.ready = 1'b1;
            draining_n = 1'b0;
            state_n = st_idle;
          end
        end else begin
          flush_step = !wb_wait || mem_rsp.ready;
          if (flush_wb.valid) begin
            mem_req = flush_wb;
            wb_wait_n = 1'b1;
          end
          if (flush_done) begin
            if (flush_wb.valid) begin
              draining_n = 1'b1;
            end else begin
              rsp.ready = 1'b1;
              state_n = st_idle;
            end
          end
        end
        if (clear_en) begin
          wr_en = 1'b1;
          wr_index = clear_index;
          wr_entry = '0;
        end
      end

      default: begin
        state_n = st_idle;
      end
    endcase
  end

  always_ff @(posedge clock) begin
    if (!reset) begin
      state <= st_idle;
      wb_wait <= 1'b0;
      draining <= 1'b0;
    end else begin
      state <= state_n;
      wb_wait <= wb_wait_n;
      draining <= draining_n;
    end
  end

endmodule

`default_nettype wire

// File: hw/dtim.sv
`default_nettype none

module dtim import dtim_pkg::*; #(
  parameter int    index_bits = default_index_bits,
  parameter addr_t base_addr = default_base_addr,
  parameter addr_t top_addr = default_top_addr
) (
  input  wire logic      clock,
  input  wire logic      reset,
  input  wire core_req_t req,
  output core_rsp_t      rsp,
  output mem_req_t       mem_req,
  input  wire mem_rsp_t  mem_rsp
);

  localparam int entry_bits = 30 - index_bits + 34;

  logic [index_bits-1:0] lookup_index;
  logic [index_bits-1:0] flush_index;
  logic [index_bits-1:0] rd_index;
  logic [entry_bits-1:0] rd_entry;
  access_e               kind;
  core_req_t             held_req;
  data_t                 line_data;
  logic                  line_dirty;
  mem_req_t              flush_wb;
  logic                  flush_start;
  logic                  flush_step;
  logic                  flush_done;
  logic                  flush_active;
  logic                  clear_en;
  logic [index_bits-1:0] clear_index;
  logic                  wr_en;
  logic [index_bits-1:0] wr_index;
  logic [entry_bits-1:0] wr_entry;

  // ------------------------------
  // array read port select
  // ------------------------------
  assign rd_index = flush_active ? flush_index : lookup_index;

  dtim_lookup #(
    .index_bits(index_bits),
    .base_addr (base_addr),
    .top_addr  (top_addr)
  ) lookup_inst (
    .clock     (clock),
    .reset     (reset),
    .req       (req),
    .rd_index  (lookup_index),
    .rd_entry  (rd_entry),
    .kind      (kind),
    .held_req  (held_req),
    .line_data (line_data),
    .line_dirty(line_dirty)
  );

  dtim_ctrl #(
    .index_bits(index_bits)
  ) ctrl_inst (
    .clock      (clock),
    .reset      (reset),
    .kind       (kind),
    .held_req   (held_req),
    .line_data  (line_data),
    .line_dirty (line_dirty),
    .mem_rsp    (mem_rsp),
    .flush_wb   (flush_wb),
    .flush_done (flush_done),
    .clear_en   (clear_en),
    .clear_index(clear_index),
    .rsp        (rsp),
    .mem_req    (mem_req),
    .flush_start(flush_start),
    .flush_step (flush_step),
    .wr_en      (wr_en),
    .wr_index   (wr_index),
    .wr_entry   (wr_entry)
  );

  dtim_flush #(
    .index_bits(index_bits)
  ) flush_inst (
    .clock      (clock),
    .reset      (reset),
    .start      (flush_start),
    .step       (flush_step),
    .rd_index   (flush_index),
    .rd_entry   (rd_entry),
    .wb_req     (flush_wb),
    .clear_en   (clear_en),
    .clear_index(clear_index),
    .done       (flush_done),
    .active     (flush_active)
  );

  dtim_ram #(
    .index_bits(index_bits)
  ) ram_inst (
    .clock   (clock),
    .rd_index(rd_index),
    .rd_entry(rd_entry),
    .wr_en   (wr_en),
    .wr_index(wr_index),
    .wr_entry(wr_entry)
  );

endmodule

`default_nettype wire

// File: tests/dtim_checker.sv
`default_nettype none

module dtim_checker import dtim_pkg::*; (
  input  wire logic      clock,
  input  wire logic      reset,
  input  wire core_req_t req,
  input  wire core_rsp_t rsp,
  input  wire mem_req_t  mem_req,
  input  wire logic [1:0] exp_op,
  input  wire data_t     exp_rdata,
  input  wire logic      wb_push,
  input  wire addr_t     wb_addr,
  input  wire data_t     wb_data,
  output int             error_count
);

  // op 1 must hit, op 2 is a fence.
  logic [1:0] cur_op;
  data_t      cur_exp;
  addr_t      wb_addr_q [$];
  data_t      wb_data_q [$];

  initial error_count = 0;

  always @(posedge clock) begin
    int found;
    if (wb_push) begin
      wb_addr_q.push_back(wb_addr);
      wb_data_q.push_back(wb_data);
    end
    if (reset && req.valid) begin
      cur_op <= exp_op;
      cur_exp <= exp_rdata;
    end
    if (reset && mem_req.valid) begin
      if (cur_op == 2'd1) begin
        $display("memory request at %h on an access that should hit", mem_req.addr);
        error_count++;
      end else if (cur_op == 2'd2) begin
        found = -1;
        foreach (wb_addr_q[i]) begin
          if (found < 0 && wb_addr_q[i] == mem_req.addr) begin
            found = i;
          end
        end
        if (found < 0) begin
          $display("unexpected fence write-back to %h", mem_req.addr);
          error_count++;
        end else begin
          if (mem_req.wdata != wb_data_q[found]) begin
            $display("ERROR mem_req.wdata got %h expected %h", mem_req.wdata,
                     wb_data_q[found]);
            error_count++;
          end
          if (mem_req.wstrb != 4'hf) begin
            $display("ERROR mem_req.wstrb got %h expected %h", mem_req.wstrb, 4'hf);
            error_count++;
          end
          wb_addr_q.delete(found);
          wb_data_q.delete(found);
        end
      end
    end
    if (reset && rsp.ready) begin
      if (rsp.rdata != cur_exp) begin
        $display("ERROR rsp.rdata got %h expected %h", rsp.rdata, cur_exp);
        error_count++;
      end
      if (cur_op == 2'd2 && wb_addr_q.size() != 0) begin
        $display("fence ended with %0d write-backs missing", wb_addr_q.size());
        error_count++;
        wb_addr_q.delete();
        wb_data_q.delete();
      end
    end
  end

endmodule

`default_nettype wire

// File: tests/dtim_assert.sv
`default_nettype none

module dtim_assert import dtim_pkg::*; (
  input wire logic        clock,
  input wire logic        reset,
  input wire ctrl_state_e state,
  input wire access_e     kind,
  input wire core_rsp_t   rsp,
  input wire mem_req_t    mem_req,
  input wire mem_rsp_t    mem_rsp
);

  logic mem_busy;

  // a memory request stays open until its ready.
  always_ff @(posedge clock) begin
    if (!reset) begin
      mem_busy <= 1'b0;
    end else if (mem_req.valid) begin
      mem_busy <= 1'b1;
    end else if (mem_rsp.ready) begin
      mem_busy <= 1'b0;
    end
  end

  // both handshakes are single cycle pulses.
  rsp_pulse: assert property (@(posedge clock) disable iff (!reset)
    rsp.ready |=> !rsp.ready) else $error("rsp ready held");

  mem_pulse: assert property (@(posedge clock) disable iff (!reset)
    mem_req.valid |=> !mem_req.valid) else $error("mem valid held");

  // the core waits for ready, so nothing is classified while a path runs.
  idle_on_request: assert property (@(posedge clock) disable iff (!reset)
    (state != st_idle) |-> kind == acc_none)
    else $error("request classified while busy");

  one_outstanding: assert property (@(posedge clock) disable iff (!reset)
    (mem_req.valid && mem_busy) |-> mem_rsp.ready)
    else $error("second memory request before ready");

endmodule

bind dtim_ctrl dtim_assert assert_inst (
  .clock  (clock),
  .reset  (reset),
  .state  (state),
  .kind   (kind),
  .rsp    (rsp),
  .mem_req(mem_req),
  .mem_rsp(mem_rsp)
);

`default_nettype wire

// File: tests/dtim_tb.sv
`default_nettype none

module dtim_tb import dtim_pkg::*;;

  logic      clock = 1'b0;
  logic      reset;
  core_req_t req;
  core_rsp_t rsp;
  mem_req_t  mem_req;
  mem_rsp_t  mem_rsp;

  logic [1:0]  exp_op;
  data_t       exp_rdata;
  logic        wb_push;
  addr_t       wb_addr;
  data_t       wb_data;
  int          error_count;

  // operations loaded from the data file.
  logic [3:0]  op_q [$];
  addr_t       addr_q [$];
  data_t       wdata_q [$];
  strb_t       strb_q [$];
  data_t       expect_q [$];
  logic        loaded = 1'b0;
  int          fence_count = 0;

  // memory model.
  logic [31:0] mem [4096];
  logic [31:0] lfsr = 32'h1cc4_0fbf;
  logic        busy;
  int          wait_count;
  mem_req_t    pending;

  always #4 clock = ~clock;

  dtim #(
    .index_bits(4),
    .base_addr (32'h0000_1000),
    .top_addr  (32'h0000_2000)
  ) dtim_inst (
    .clock  (clock),
    .reset  (reset),
    .req    (req),
    .rsp    (rsp),
    .mem_req(mem_req),
    .mem_rsp(mem_rsp)
  );

  dtim_checker checker_inst (
    .clock      (clock),
    .reset      (reset),
    .req        (req),
    .rsp        (rsp),
    .mem_req    (mem_req),
    .exp_op     (exp_op),
    .exp_rdata  (exp_rdata),
    .wb_push    (wb_push),
    .wb_addr    (wb_addr),
    .wb_data    (wb_data),
    .error_count(error_count)
  );

  // one galois lfsr step per bit taken.
  function automatic logic [31:0] lfsr_step(logic [31:0] value);
    return value[0] ? ((value >> 1) ^ 32'h8020_0003) : (value >> 1);
  endfunction

  // ------------------------------
  // memory model
  // ------------------------------
  initial begin
    for (int i = 0; i < 4096; i++) begin
      mem[i] = {20'hc0de0, i[11:0]};
    end
  end

  always @(posedge clock) begin
    logic [31:0] next_lfsr;
    logic [31:0] word;
    mem_rsp <= '0;
    if (!reset) begin
      busy <= 1'b0;
    end else if (busy) begin
      if (wait_count == 1) begin
        busy <= 1'b0;
        mem_rsp.ready <= 1'b1;
        if (pending.wstrb == 4'h0) begin
          mem_rsp.rdata <= mem[pending.addr[13:2]];
        end else begin
          word = mem[pending.addr[13:2]];
          for (int i = 0; i < 4; i++) begin
            if (pending.wstrb[i]) begin
              word[8*i +: 8] = pending.wdata[8*i +: 8];
            end
          end
          mem[pending.addr[13:2]] <= word;
        end
      end else begin
        wait_count <= wait_count - 1;
      end
    end else if (mem_req.valid) begin
      next_lfsr = lfsr_step(lfsr);
      wait_count <= 1 + int'({next_lfsr[0], lfsr[0]});
      lfsr <= lfsr_step(next_lfsr);
      busy <= 1'b1;
      pending <= mem_req;
    end
  end

  task automatic load_file(output logic ok);
    int    fd;
    int    n;
    string line;
    logic [3:0] op;
    addr_t a;
    data_t d;
    strb_t s;
    data_t e;
    ok = 1'b0;
    fd = $fopen("tests/dtim_input.txt", "r");
    if (fd != 0) begin
      ok = 1'b1;
      while (!$feof(fd)) begin
        if ($fgets(line, fd) > 0 && line.len() > 1 && line[0] != "#") begin
          n = $sscanf(line, "%h %h %h %h %h", op, a, d, s, e);
          if (n == 5) begin
            op_q.push_back(op);
            addr_q.push_back(a);
            wdata_q.push_back(d);
            strb_q.push_back(s);
            expect_q.push_back(e);
            if (op == 4'h2) begin
              fence_count++;
            end
          end
        end
      end
      $fclose(fd);
    end
  endtask

  task automatic issue(int k);
    @(posedge clock);
    req.valid <= 1'b1;
    req.fence <= (op_q[k] == 4'h2);
    req.addr <= addr_q[k];
    req.wdata <= wdata_q[k];
    req.wstrb <= strb_q[k];
    exp_op <= op_q[k][1:0];
    exp_rdata <= expect_q[k];
    @(posedge clock);
    req <= '0;
    while (!rsp.ready) begin
      @(posedge clock);
    end
  endtask

  task automatic push_writeback(int k);
    @(posedge clock);
    wb_push <= 1'b1;
    wb_addr <= addr_q[k];
    wb_data <= expect_q[k];
    @(posedge clock);
    wb_push <= 1'b0;
  endtask

  // ------------------------------
  // stimulus
  // ------------------------------
  initial begin
    logic ok;
    reset = 1'b0;
    req = '0;
    mem_rsp = '0;
    exp_op = '0;
    exp_rdata = '0;
    wb_push = 1'b0;
    wb_addr = '0;
    wb_data = '0;
    load_file(ok);
    if (!ok) begin
      $display("could not open the stimulus file");
      $display("TESTBENCH FAILED");
      $finish;
    end else begin
      loaded = 1'b1;
      repeat (3) @(posedge clock);
      reset <= 1'b1;
      for (int k = 0; k < op_q.size(); k++) begin
        if (op_q[k] == 4'h3) begin
          push_writeback(k);
        end else begin
          issue(k);
        end
      end
      repeat (4) @(posedge clock);
      $display("%0d operations, %0d errors", op_q.size(), error_count);
      if (error_count == 0) begin
        $display("TESTBENCH PASSED");
      end else begin
        $display("TESTBENCH FAILED");
      end
      $finish;
    end
  end

  // watchdog.
  initial begin
    wait (loaded);
    repeat (op_q.size() * 40 + fence_count * 16 * 16) @(posedge clock);
    $display("the run timed out waiting for a response");
    $display("TESTBENCH FAILED");
    $finish;
  end

endmodule

`default_nettype wire

// File: tests/dtim_input.txt
# op: 0 access, 1 access that must hit, 2 fence, 3 expected fence write-back
# op addr wdata strb expected_rdata (write-back data for op 3)
0 00001000 00000000 0 c0de0400
1 00001000 00000000 0 c0de0400
1 00001000 11223344 3 c0de0400
1 00001000 00000000 0 c0de3344
0 00001008 aabbccdd c c0de0402
1 00001008 00000000 0 aabb0402
0 00003000 00000000 0 c0de0c00
0 00001040 00000000 0 c0de0410
0 00001040 12345678 f 00000000
0 00001040 00000000 0 12345678
1 00001000 00000000 0 c0de3344
0 00001004 00000000 0 c0de0401
3 00001000 00000000 f c0de3344
3 00001008 00000000 f aabb0402
2 00000000 00000000 0 00000000
0 00001000 00000000 0 c0de3344
0 00001008 00000000 0 aabb0402
0 00001004 00000000 0 c0de0401
1 00001004 00000000 0 c0de0401
2 00000000 00000000 0 00000000
0 00001000 00000000 0 c0de3344

// File: tb.f
hw/dtim_pkg.sv
hw/dtim_ram.sv
hw/dtim_lookup.sv
hw/dtim_flush.sv
hw/dtim_ctrl.sv
hw/dtim.sv
tests/dtim_checker.sv
tests/dtim_assert.sv
tests/dtim_tb.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --assert --top-module dtim_tb -f tb.f -o dtim_sim
./obj_dir/dtim_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "TESTBENCH FAILED" sim.log; then
  exit 1
fi
grep -q "TESTBENCH PASSED" sim.log
